/* fetch_settings.svh */
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// eight halfwords per fetch block
`define FETCH_BLOCK_BYTES 16

// PC file holds 2**FETCH_ID_BITS blocks
`define FETCH_ID_BITS 4

// direct-mapped BTB size
`define BTB_ENTRIES 8

// execute-stage branch sources
`define NUM_BRANCH_PROVS 2

`define PCF_READ_PORTS 2

// ROB sequence number width
`define SQN_BITS 6

`endif

/* fetchPkg.sv */
`default_nettype none

`include "fetch_settings.svh"

package fetchPkg;

    localparam int blockHalfwords = `FETCH_BLOCK_BYTES / 2;
    localparam int pcfDepth = 2 ** `FETCH_ID_BITS;

    typedef logic [`FETCH_ID_BITS-1:0] fetchId_t;

    // PC bits 31..4
    typedef logic [27:0] blockAddr_t;

    // halfword index inside a block
    typedef logic [2:0] slot_t;

    // slot value meaning no predicted branch
    localparam slot_t noPredSlot = 3'd7;

    typedef enum logic [1:0] {
        IF_FAULT_NONE = 2'd0
    } fetchFault_t;

    // per-block record read back by later stages
    typedef struct packed {
        logic [31:0] pc;
        slot_t predSlot;
        logic predTaken;
    } pcFileEntry_t;

    typedef struct packed {
        logic valid;
        blockAddr_t blockAddr;
        fetchId_t fetchId;
        fetchFault_t fault;
        logic predTaken;
        slot_t predSlot;
        slot_t firstValid;
        slot_t lastValid;
        logic [31:0] predTarget;
        logic [blockHalfwords-1:0][15:0] instrs;
    } fetchBlock_t;

endpackage

`default_nettype wire

/* branchPkg.sv */
`default_nettype none

`include "fetch_settings.svh"

package branchPkg;

    localparam int btbIdxBits = $clog2(`BTB_ENTRIES);

    typedef logic [`SQN_BITS-1:0] sqN_t;

    // PC bits above the index
    typedef logic [27-btbIdxBits:0] btbTag_t;

    // resolved branch from one execute unit
    typedef struct packed {
        logic taken;
        logic [31:0] dstPc;
        fetchPkg::fetchId_t fetchId;
        sqN_t sqN;
    } branchProv_t;

    typedef struct packed {
        logic taken;
        logic [31:0] dstPc;
        fetchPkg::fetchId_t fetchId;
    } decodeBranch_t;

    typedef struct packed {
        logic valid;
        logic [31:0] srcPc;
        logic [31:0] dstPc;
    } btbUpdate_t;

    typedef struct packed {
        logic valid;
        btbTag_t tag;
        fetchPkg::slot_t srcSlot;
        logic [31:0] target;
    } btbEntry_t;

endpackage

`default_nettype wire

/* indexedStore.sv */
`default_nettype none

module indexedStore #(
    parameter type entryT = logic,
    parameter int depth = 16,
    parameter int readPorts = 1
) (
    input logic clk,
    input logic rst,
    input logic wen,
    input logic [$clog2(depth)-1:0] waddr,
    input entryT wdata,
    input logic [$clog2(depth)-1:0] raddr [readPorts],
    output entryT rdata [readPorts]
);

    entryT entries [depth];
    logic [depth-1:0] entryValid;

    // only the valid bits see reset
    always_ff @(posedge clk) begin
        if (rst) begin
            entryValid <= '0;
        end else if (wen) begin
            entryValid[waddr] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wen) begin
            entries[waddr] <= wdata;
        end
    end

    // unwritten entries read as zero
    always_comb begin
        for (int p = 0; p < readPorts; p++) begin
            if (entryValid[raddr[p]]) begin
                rdata[p] = entries[raddr[p]];
            end else begin
                rdata[p] = entryT'('0);
            end
        end
    end

endmodule

`default_nettype wire

/* redirectSelect.sv */
`default_nettype none

`include "fetch_settings.svh"

module redirectSelect (
    input logic clk,
    input logic rst,
    input branchPkg::branchProv_t branches [`NUM_BRANCH_PROVS],
    input branchPkg::sqN_t robCurSqN,
    input logic mispredFlush,
    output branchPkg::branchProv_t outBranch,
    output logic misprCount
);

    import branchPkg::*;

    branchProv_t oldest;
    logic oldestValid;

    // age is distance from the ROB head, so wraparound is harmless
    always_comb begin
        sqN_t age;
        sqN_t bestAge;
        oldest = branches[0];
        oldestValid = 1'b0;
        bestAge = '1;
        for (int i = 0; i < `NUM_BRANCH_PROVS; i++) begin
            age = branches[i].sqN - robCurSqN;
            if (branches[i].taken && (!oldestValid || age < bestAge)) begin
                oldest = branches[i];
                oldestValid = 1'b1;
                bestAge = age;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outBranch.taken <= 1'b0;
            misprCount <= 1'b0;
        end else begin
            outBranch <= oldest;
            // flush suppresses any redirect
            outBranch.taken <= oldestValid && !mispredFlush;
            misprCount <= oldestValid && !mispredFlush;
        end
    end

endmodule

`default_nettype wire

/* branchTargetBuffer.sv */
`default_nettype none

`include "fetch_settings.svh"

module branchTargetBuffer (
    input logic clk,
    input logic rst,
    input logic [31:0] lookupPc,
    output logic hit,
    output fetchPkg::slot_t srcSlot,
    output logic [31:0] target,
    input branchPkg::btbUpdate_t update
);

    import fetchPkg::*;
    import branchPkg::*;

    logic [btbIdxBits-1:0] readIdx [1];
    btbEntry_t readEntry [1];

    logic [btbIdxBits-1:0] writeIdx;
    btbEntry_t writeEntry;

    btbTag_t lookupTag;
    slot_t lookupSlot;
    btbEntry_t entry;

    // index from bits just above the block offset
    assign readIdx[0] = lookupPc[4 +: btbIdxBits];
    assign lookupTag = lookupPc[31:4+btbIdxBits];
    assign lookupSlot = lookupPc[3:1];

    assign writeIdx = update.srcPc[4 +: btbIdxBits];

    always_comb begin
        writeEntry.valid = 1'b1;
        writeEntry.tag = update.srcPc[31:4+btbIdxBits];
        writeEntry.srcSlot = update.srcPc[3:1];
        writeEntry.target = update.dstPc;
    end

    indexedStore #(
        .entryT(btbEntry_t),
        .depth(`BTB_ENTRIES),
        .readPorts(1)
    ) btbStore (
        .clk(clk),
        .rst(rst),
        .wen(update.valid),
        .waddr(writeIdx),
        .wdata(writeEntry),
        .raddr(readIdx),
        .rdata(readEntry)
    );

    assign entry = readEntry[0];

    // a branch before the fetch entry point in the block does not count
    assign hit = entry.valid && (entry.tag == lookupTag) && (entry.srcSlot >= lookupSlot);
    assign srcSlot = entry.srcSlot;
    assign target = entry.target;

endmodule

`default_nettype wire

/* fetchSequencer.sv */
`default_nettype none

`include "fetch_settings.svh"

module fetchSequencer (
    input logic clk,
    input logic rst,
    input logic en,
    input fetchPkg::fetchId_t robCurFetchID,
    input branchPkg::branchProv_t selBranch,
    input branchPkg::decodeBranch_t decBranch,
    input logic btbHit,
    input fetchPkg::slot_t btbSlot,
    input logic [31:0] btbTarget,
    output logic [31:0] lookupPc,
    output logic instrReadEnable,
    output fetchPkg::blockAddr_t instrAddr,
    input logic [`FETCH_BLOCK_BYTES*8-1:0] instrRaw,
    output logic pcfWen,
    output fetchPkg::fetchId_t pcfWaddr,
    output fetchPkg::pcFileEntry_t pcfWdata,
    output fetchPkg::fetchBlock_t instrs,
    output logic stall
);

    import fetchPkg::*;

    logic [31:0] pc;
    fetchId_t fetchId;

    // block fetched last cycle that waits for its data
    logic fetchValid;
    logic [31:0] fetchPc;
    logic fetchPredTaken;
    slot_t fetchPredSlot;
    logic [31:0] fetchPredTarget;

    fetchBlock_t outBlock;

    logic [`FETCH_BLOCK_BYTES*8-1:0] rawBackup;
    logic [`FETCH_BLOCK_BYTES*8-1:0] rawData;
    logic useBackup;

    logic redirect;
    logic advance;
    logic [31:0] nextPc;

    assign redirect = selBranch.taken || decBranch.taken;
    assign stall = (fetchId == robCurFetchID);
    assign advance = en && !stall && !redirect;

    assign lookupPc = pc;
    assign nextPc = btbHit ? btbTarget : {pc[31:4] + 28'd1, 4'd0};

    // memory reads at the edge that registers the block
    assign instrReadEnable = fetchValid && advance;
    assign instrAddr = fetchPc[31:4];

    assign pcfWen = fetchValid && advance;
    assign pcfWaddr = fetchId;

    always_comb begin
        pcfWdata.pc = fetchPc;
        pcfWdata.predSlot = fetchPredSlot;
        pcfWdata.predTaken = fetchPredTaken;
    end

    // keep the raw block steady while fetch is disabled
    always_ff @(posedge clk) begin
        if (rst) begin
            useBackup <= 1'b0;
        end else if (!en) begin
            rawBackup <= rawData;
            useBackup <= 1'b1;
        end else begin
            useBackup <= 1'b0;
        end
    end

    assign rawData = useBackup ? rawBackup : instrRaw;

    always_comb begin
        instrs = outBlock;
        instrs.instrs = rawData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
            fetchId <= '0;
            fetchValid <= 1'b0;
            outBlock.valid <= 1'b0;
        end else if (selBranch.taken) begin
            // execute redirect wins over decode
            pc <= selBranch.dstPc;
            fetchId <= selBranch.fetchId + 1'b1;
            fetchValid <= 1'b0;
            outBlock.valid <= 1'b0;
        end else if (decBranch.taken) begin
            pc <= decBranch.dstPc;
            fetchId <= decBranch.fetchId + 1'b1;
            fetchValid <= 1'b0;
            outBlock.valid <= 1'b0;
        end else if (en) begin
            if (stall) begin
                outBlock.valid <= 1'b0;
            end else begin
                if (fetchValid) begin
                    outBlock.valid <= 1'b1;
                    outBlock.blockAddr <= fetchPc[31:4];
                    outBlock.fetchId <= fetchId;
                    outBlock.fault <= IF_FAULT_NONE;
                    outBlock.predTaken <= fetchPredTaken;
                    outBlock.predSlot <= fetchPredSlot;
                    outBlock.firstValid <= fetchPc[3:1];
                    outBlock.lastValid <= fetchPredSlot;
                    outBlock.predTarget <= fetchPredTarget;
                    outBlock.instrs <= '0;
                    fetchId <= fetchId + 1'b1;
                end else begin
                    outBlock.valid <= 1'b0;
                end

                fetchValid <= 1'b1;
                fetchPc <= pc;
                fetchPredTaken <= btbHit;
                fetchPredSlot <= btbHit ? btbSlot : noPredSlot;
                fetchPredTarget <= btbHit ? btbTarget : 32'd0;
                pc <= nextPc;
            end
        end
    end

endmodule

`default_nettype wire

/* fetchUnit.sv */
`default_nettype none

`include "fetch_settings.svh"

module fetchUnit (
    input logic clk,
    input logic rst,
    input logic en,

    output logic instrReadEnable,
    output fetchPkg::blockAddr_t instrAddr,
    input logic [`FETCH_BLOCK_BYTES*8-1:0] instrRaw,

    input branchPkg::branchProv_t branches [`NUM_BRANCH_PROVS],
    input logic mispredFlush,
    input branchPkg::sqN_t robCurSqN,
    input fetchPkg::fetchId_t robCurFetchID,

    input branchPkg::decodeBranch_t decBranch,
    input branchPkg::btbUpdate_t btUpdate,

    input fetchPkg::fetchId_t pcReadAddr [`PCF_READ_PORTS],
    output fetchPkg::pcFileEntry_t pcReadData [`PCF_READ_PORTS],

    output fetchPkg::fetchBlock_t instrs,
    output branchPkg::branchProv_t outBranch,
    output logic misprCount,
    output logic stall
);

    import fetchPkg::*;

    logic [31:0] lookupPc;
    logic btbHit;
    slot_t btbSlot;
    logic [31:0] btbTarget;

    logic pcfWen;
    fetchId_t pcfWaddr;
    pcFileEntry_t pcfWdata;

    redirectSelect redirectSel (
        .clk(clk),
        .rst(rst),
        .branches(branches),
        .robCurSqN(robCurSqN),
        .mispredFlush(mispredFlush),
        .outBranch(outBranch),
        .misprCount(misprCount)
    );

    branchTargetBuffer btb (
        .clk(clk),
        .rst(rst),
        .lookupPc(lookupPc),
        .hit(btbHit),
        .srcSlot(btbSlot),
        .target(btbTarget),
        .update(btUpdate)
    );

    fetchSequencer sequencer (
        .clk(clk),
        .rst(rst),
        .en(en),
        .robCurFetchID(robCurFetchID),
        .selBranch(outBranch),
        .decBranch(decBranch),
        .btbHit(btbHit),
        .btbSlot(btbSlot),
        .btbTarget(btbTarget),
        .lookupPc(lookupPc),
        .instrReadEnable(instrReadEnable),
        .instrAddr(instrAddr),
        .instrRaw(instrRaw),
        .pcfWen(pcfWen),
        .pcfWaddr(pcfWaddr),
        .pcfWdata(pcfWdata),
        .instrs(instrs),
        .stall(stall)
    );

    // one entry per in-flight fetch ID
    indexedStore #(
        .entryT(pcFileEntry_t),
        .depth(pcfDepth),
        .readPorts(`PCF_READ_PORTS)
    ) pcFile (
        .clk(clk),
        .rst(rst),
        .wen(pcfWen),
        .waddr(pcfWaddr),
        .wdata(pcfWdata),
        .raddr(pcReadAddr),
        .rdata(pcReadData)
    );

endmodule

`default_nettype wire

/* tb_fetchUnit.sv */
`default_nettype none

`include "fetch_settings.svh"

module tb_fetchUnit;

    import fetchPkg::*;
    import branchPkg::*;

    localparam int clkPeriod = 10;
    // the tests need well under 300 cycles
    localparam int watchdogCycles = 2000;
    localparam int validLimit = 20;

    logic clk;
    logic rst;
    logic en;
    logic instrReadEnable;
    blockAddr_t instrAddr;
    logic [`FETCH_BLOCK_BYTES*8-1:0] instrRaw;
    branchProv_t branches [`NUM_BRANCH_PROVS];
    logic mispredFlush;
    sqN_t robCurSqN;
    fetchId_t robCurFetchID;
    decodeBranch_t decBranch;
    btbUpdate_t btUpdate;
    fetchId_t pcReadAddr [`PCF_READ_PORTS];
    pcFileEntry_t pcReadData [`PCF_READ_PORTS];
    fetchBlock_t instrs;
    branchProv_t outBranch;
    logic misprCount;
    logic stall;

    int errors;
    int timeouts;
    logic [31:0] expPc [pcfDepth];

    logic memRdEn;
    blockAddr_t memRdAddr;

    fetchUnit dut_i (
        .clk(clk),
        .rst(rst),
        .en(en),
        .instrReadEnable(instrReadEnable),
        .instrAddr(instrAddr),
        .instrRaw(instrRaw),
        .branches(branches),
        .mispredFlush(mispredFlush),
        .robCurSqN(robCurSqN),
        .robCurFetchID(robCurFetchID),
        .decBranch(decBranch),
        .btUpdate(btUpdate),
        .pcReadAddr(pcReadAddr),
        .pcReadData(pcReadData),
        .instrs(instrs),
        .outBranch(outBranch),
        .misprCount(misprCount),
        .stall(stall)
    );

    always #(clkPeriod / 2) clk = ~clk;

    // each halfword holds its own byte address divided by two
    function automatic logic [`FETCH_BLOCK_BYTES*8-1:0] memBlock(input blockAddr_t addr);
        logic [31:0] byteAddr;
        logic [`FETCH_BLOCK_BYTES*8-1:0] data;
        for (int i = 0; i < blockHalfwords; i++) begin
            byteAddr = {addr, 4'h0} + 32'(2 * i);
            data[16*i +: 16] = byteAddr[16:1];
        end
        return data;
    endfunction

    // instruction memory returns data one cycle after the read
    always @(posedge clk) begin
        memRdEn = instrReadEnable;
        memRdAddr = instrAddr;
        #1;
        if (memRdEn) begin
            instrRaw = memBlock(memRdAddr);
        end else begin
            // bus carries no block without a read
            instrRaw = '1;
        end
    end

    task automatic logError(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic waitValid(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!instrs.valid && n < validLimit) begin
            @(negedge clk);
            n++;
        end
        if (!instrs.valid) begin
            timeouts++;
            $display("timeout: no valid fetch block within %0d cycles (%s)", validLimit, what);
        end
    endtask

    task automatic checkBlock(input blockAddr_t addr, input fetchId_t id, input slot_t first,
                              input slot_t last, input logic taken, input slot_t pSlot,
                              input logic [31:0] pTarget, input string tag);
        logic [15:0] expHw;
        if (instrs.blockAddr !== addr)
            logError($sformatf("%s: block address %h, expected %h", tag, instrs.blockAddr, addr));
        if (instrs.fetchId !== id)
            logError($sformatf("%s: fetch ID %0d, expected %0d", tag, instrs.fetchId, id));
        if (instrs.fault !== IF_FAULT_NONE)
            logError($sformatf("%s: fault field set", tag));
        if (instrs.firstValid !== first)
            logError($sformatf("%s: first slot %0d, expected %0d", tag, instrs.firstValid, first));
        if (instrs.lastValid !== last)
            logError($sformatf("%s: last slot %0d, expected %0d", tag, instrs.lastValid, last));
        if (instrs.predTaken !== taken)
            logError($sformatf("%s: predicted taken %b, expected %b", tag, instrs.predTaken, taken));
        if (instrs.predSlot !== pSlot)
            logError($sformatf("%s: predicted slot %0d, expected %0d", tag, instrs.predSlot, pSlot));
        if (taken && instrs.predTarget !== pTarget)
            logError($sformatf("%s: target %h, expected %h", tag, instrs.predTarget, pTarget));
        for (int i = 0; i < blockHalfwords; i++) begin
            expHw = 16'({addr, 3'b000} + 31'(i));
            if (instrs.instrs[i] !== expHw)
                logError($sformatf("%s: halfword %0d is %h, expected %h", tag, i,
                                   instrs.instrs[i], expHw));
        end
    endtask

    task automatic decodeRedirect(input logic [31:0] dst, input fetchId_t id);
        @(posedge clk);
        #1;
        decBranch.taken = 1'b1;
        decBranch.dstPc = dst;
        decBranch.fetchId = id;
        @(posedge clk);
        #1;
        decBranch.taken = 1'b0;
    endtask

    task automatic sequentialFetch();
        for (int k = 0; k < 10; k++) begin
            waitValid("sequential fetch");
            checkBlock(28'(k), fetchId_t'(k), 3'd0, 3'd7, 1'b0, 3'd7, 32'd0, "sequential");
            expPc[k] = 32'(k) << 4;
        end
    endtask

    task automatic pcFileReadback();
        for (int k = 0; k < 10; k++) begin
            @(posedge clk);
            #1;
            pcReadAddr[0] = fetchId_t'(k);
            pcReadAddr[1] = fetchId_t'(9 - k);
            @(negedge clk);
            if (pcReadData[0].pc !== expPc[k])
                logError($sformatf("PC file port 0 ID %0d: %h, expected %h", k,
                                   pcReadData[0].pc, expPc[k]));
            if (pcReadData[1].pc !== expPc[9-k])
                logError($sformatf("PC file port 1 ID %0d: %h, expected %h", 9 - k,
                                   pcReadData[1].pc, expPc[9-k]));
        end
    endtask

    task automatic unalignedRedirect();
        logic [31:0] dst;
        dst = $urandom & 32'hFFFF_FFFE;
        decodeRedirect(dst, 4'd2);
        waitValid("decode redirect");
        checkBlock(dst[31:4], 4'd3, dst[3:1], 3'd7, 1'b0, 3'd7, 32'd0, "decode redirect");
    endtask

    task automatic btbPrediction();
        logic [31:0] src;
        logic [31:0] dst;
        src = 32'h0000_1236;
        dst = 32'h0000_4A50;
        @(posedge clk);
        #1;
        btUpdate.valid = 1'b1;
        btUpdate.srcPc = src;
        btUpdate.dstPc = dst;
        @(posedge clk);
        #1;
        btUpdate.valid = 1'b0;
        decodeRedirect({src[31:4], 4'h0}, 4'd5);
        waitValid("BTB source block");
        checkBlock(src[31:4], 4'd6, 3'd0, src[3:1], 1'b1, src[3:1], dst, "BTB source");
        @(posedge clk);
        #1;
        pcReadAddr[0] = 4'd6;
        waitValid("BTB target block");
        checkBlock(dst[31:4], 4'd7, dst[3:1], 3'd7, 1'b0, 3'd7, 32'd0, "BTB target");
        if (pcReadData[0].pc !== {src[31:4], 4'h0} || pcReadData[0].predTaken !== 1'b1 ||
            pcReadData[0].predSlot !== src[3:1])
            logError($sformatf("PC file ID 6: pc %h taken %b slot %0d, expected %h 1 %0d",
                               pcReadData[0].pc, pcReadData[0].predTaken,
                               pcReadData[0].predSlot, {src[31:4], 4'h0}, src[3:1]));
    endtask

    task automatic executeProviders();
        branchProv_t winner;
        @(posedge clk);
        #1;
        robCurSqN = 6'd60;
        branches[0] = '{taken: 1'b1, dstPc: 32'h0000_8040, fetchId: 4'd4, sqN: 6'd2};
        branches[1] = '{taken: 1'b1, dstPc: 32'h0000_9A06, fetchId: 4'd7, sqN: 6'd62};
        // head at 60 makes sqN 62 two entries old and sqN 2 six
        winner = branches[1];
        @(posedge clk);
        #1;
        branches[0].taken = 1'b0;
        branches[1].taken = 1'b0;
        @(negedge clk);
        if (!outBranch.taken || outBranch.dstPc !== winner.dstPc || outBranch.sqN !== winner.sqN)
            logError($sformatf("selected branch sqN %0d dst %h, expected sqN %0d dst %h",
                               outBranch.sqN, outBranch.dstPc, winner.sqN, winner.dstPc));
        if (misprCount !== 1'b1)
            logError("no count pulse for the selected branch");
        waitValid("execute redirect");
        checkBlock(winner.dstPc[31:4], winner.fetchId + 4'd1, winner.dstPc[3:1], 3'd7, 1'b0,
                   3'd7, 32'd0, "execute redirect");

        @(posedge clk);
        #1;
        branches[0].taken = 1'b1;
        branches[1].taken = 1'b1;
        mispredFlush = 1'b1;
        @(posedge clk);
        #1;
        branches[0].taken = 1'b0;
        branches[1].taken = 1'b0;
        mispredFlush = 1'b0;
        @(negedge clk);
        if (outBranch.taken !== 1'b0)
            logError("branch selected while flush was high");
        if (misprCount !== 1'b0)
            logError("count pulse while flush was high");
    endtask

    task automatic stallAndEnable();
        fetchBlock_t held;
        fetchId_t lastId;
        decodeRedirect(32'h0000_A000, 4'd9);
        waitValid("stall setup");
        lastId = instrs.fetchId;
        @(posedge clk);
        #1;
        // one more block lands at that edge
        robCurFetchID = lastId + 4'd2;
        @(negedge clk);
        if (stall !== 1'b1)
            logError("stall low with ROB fetch ID equal to the next fetch ID");
        repeat (5) begin
            @(negedge clk);
            if (instrs.valid !== 1'b0)
                logError($sformatf("block with fetch ID %0d during stall", instrs.fetchId));
        end
        @(posedge clk);
        #1;
        robCurFetchID = 4'd15;
        waitValid("after stall");
        @(posedge clk);
        #1;
        en = 1'b0;
        @(negedge clk);
        held = instrs;
        repeat (5) begin
            @(negedge clk);
            if (instrs !== held)
                logError("block output changed while en was low");
        end
        @(posedge clk);
        #1;
        en = 1'b1;
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdogCycles);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        void'($urandom(72199));
        errors = 0;
        timeouts = 0;
        clk = 1'b0;
        rst = 1'b1;
        en = 1'b1;
        instrRaw = '0;
        for (int i = 0; i < `NUM_BRANCH_PROVS; i++) begin
            branches[i] = '0;
        end
        mispredFlush = 1'b0;
        robCurSqN = '0;
        robCurFetchID = 4'd15;
        decBranch = '0;
        btUpdate = '0;
        for (int p = 0; p < `PCF_READ_PORTS; p++) begin
            pcReadAddr[p] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        sequentialFetch();
        pcFileReadback();
        unalignedRedirect();
        btbPrediction();
        executeProviders();
        stallAndEnable();

        $display("mismatches: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
fetchPkg.sv
branchPkg.sv
indexedStore.sv
redirectSelect.sv
branchTargetBuffer.sv
fetchSequencer.sv
fetchUnit.sv
tb_fetchUnit.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module tb_fetchUnit \
    -o simv > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0
